// File: design/storage_pkg.sv
package storage_pkg;

    // Block decode uses address bits 23:16
    localparam logic [23:0] ADR_MASK     = 24'hFF_0000;
    localparam logic [23:0] BLOCK_STRIDE = 24'h01_0000;
    localparam int          MAX_BLOCKS   = 8;

    localparam int WORD_ADR_W = 8;
    localparam int DATA_W     = 32;

    // Base table, entry i sits at i strides
    localparam logic [23:0] MGMT_BLOCK_ADR [MAX_BLOCKS] = '{
        BLOCK_STRIDE * 24'd0, BLOCK_STRIDE * 24'd1,
        BLOCK_STRIDE * 24'd2, BLOCK_STRIDE * 24'd3,
        BLOCK_STRIDE * 24'd4, BLOCK_STRIDE * 24'd5,
        BLOCK_STRIDE * 24'd6, BLOCK_STRIDE * 24'd7
    };

    localparam logic [23:0] USER_BLOCK_ADR [MAX_BLOCKS] = '{
        BLOCK_STRIDE * 24'd0, BLOCK_STRIDE * 24'd1,
        BLOCK_STRIDE * 24'd2, BLOCK_STRIDE * 24'd3,
        BLOCK_STRIDE * 24'd4, BLOCK_STRIDE * 24'd5,
        BLOCK_STRIDE * 24'd6, BLOCK_STRIDE * 24'd7
    };

    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_RD_WAIT,
        ACK_PULSE
    } ack_state_e;

    // Derived from cyc, stb and we
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } access_op_e;

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if #(
    parameter int BLOCKS = 2
);
    import storage_pkg::*;

    // Per-block enables, active low
    logic [BLOCKS-1:0]        ena_n;
    logic [WORD_ADR_W-1:0]    addr;
    logic                     wen_n;
    logic [3:0]               wen_mask;
    logic [DATA_W-1:0]        wdata;
    // One registered word per block
    logic [BLOCKS*DATA_W-1:0] rdata;

    modport router (
        output ena_n,
        output addr,
        input  rdata
    );

    modport writer (
        output wen_n,
        output wen_mask,
        output wdata
    );

    modport mem_rw (
        input  ena_n,
        input  addr,
        input  wen_n,
        input  wen_mask,
        input  wdata,
        output rdata
    );

    modport mem_ro (
        input  ena_n,
        input  addr,
        output rdata
    );

endinterface

// File: design/storage_ctrl.sv
`timescale 1ns/10ps

module storage_ctrl (
    input  logic                           wb_clk_i,
    input  logic                           rst_n_i,
    input  logic                           wb_cyc_i,
    input  logic [1:0]                     wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [3:0]                     wb_sel_i,
    input  logic [storage_pkg::DATA_W-1:0] wb_dat_i,
    output logic [1:0]                     wb_ack_o,
    output logic [1:0]                     valid_o,
    mem_bus_if.writer                      mgmt_bus
);
    import storage_pkg::*;

    logic [1:0] valid;
    access_op_e op [2];
    ack_state_e state_q [2];
    logic       mgmt_wr;

    // Nothing is qualified while reset is asserted
    assign valid   = {2{wb_cyc_i & rst_n_i}} & wb_stb_i;
    assign valid_o = valid;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (!valid[k]) begin
                op[k] = OP_NONE;
            end else if (wb_we_i) begin
                op[k] = OP_WRITE;
            end else begin
                op[k] = OP_READ;
            end
        end
    end

    // One ack engine per strobe bit
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 2'b00;
            for (int k = 0; k < 2; k++) begin
                state_q[k] <= ACK_IDLE;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                case (state_q[k])
                    ACK_IDLE: begin
                        wb_ack_o[k] <= (op[k] == OP_WRITE);
                        if (op[k] == OP_WRITE) begin
                            state_q[k] <= ACK_PULSE;
                        end else if (op[k] == OP_READ) begin
                            state_q[k] <= ACK_RD_WAIT;
                        end
                    end
                    ACK_RD_WAIT: begin
                        // SRAM word is registered by now
                        if (op[k] == OP_READ) begin
                            wb_ack_o[k] <= 1'b1;
                            state_q[k]  <= ACK_PULSE;
                        end else begin
                            wb_ack_o[k] <= 1'b0;
                            state_q[k]  <= ACK_IDLE;
                        end
                    end
                    ACK_PULSE: begin
                        wb_ack_o[k] <= 1'b0;
                        // Hold here until strobe drops
                        if (op[k] == OP_NONE) begin
                            state_q[k] <= ACK_IDLE;
                        end
                    end
                    default: begin
                        wb_ack_o[k] <= 1'b0;
                        state_q[k]  <= ACK_IDLE;
                    end
                endcase
            end
        end
    end

    // Write lands on the same edge as the ack
    assign mgmt_wr           = (op[0] == OP_WRITE) && (state_q[0] == ACK_IDLE);
    assign mgmt_bus.wen_n    = ~mgmt_wr;
    assign mgmt_bus.wen_mask = wb_sel_i & {4{mgmt_wr}};
    assign mgmt_bus.wdata    = wb_dat_i;

endmodule

// File: design/storage_bank_router.sv
`timescale 1ns/10ps

module storage_bank_router #(
    parameter int          BLOCKS = 2,
    parameter logic [23:0] BLOCK_BASE [storage_pkg::MAX_BLOCKS] = storage_pkg::MGMT_BLOCK_ADR
) (
    input  logic                           valid_i,
    input  logic [31:0]                    wb_adr_i,
    output logic [storage_pkg::DATA_W-1:0] dat_o,
    mem_bus_if.router                      bus
);
    import storage_pkg::*;

    logic [23:0]       masked_adr;
    logic [BLOCKS-1:0] sel;

    assign masked_adr = wb_adr_i[23:0] & ADR_MASK;

    // One-hot block select from the base table
    always_comb begin
        for (int b = 0; b < BLOCKS; b++) begin
            sel[b] = (masked_adr == BLOCK_BASE[b]);
        end
    end

    assign bus.ena_n = valid_i ? ~sel : {BLOCKS{1'b1}};
    assign bus.addr  = wb_adr_i[WORD_ADR_W-1:0];

    // No hit leaves the result at zero
    always_comb begin
        dat_o = '0;
        for (int b = 0; b < BLOCKS; b++) begin
            dat_o = dat_o | (bus.rdata[b*DATA_W +: DATA_W] & {DATA_W{sel[b]}});
        end
    end

endmodule

// File: design/mgmt_sram_bank.sv
`timescale 1ns/10ps

module mgmt_sram_bank #(
    parameter int BLOCKS = 2
) (
    input  logic   wb_clk_i,
    mem_bus_if.mem_rw bus
);
    import storage_pkg::*;

    // Behavioral stand-in for the SRAM macros
    logic [DATA_W-1:0]             mem [BLOCKS][2**WORD_ADR_W];
    logic [BLOCKS-1:0][DATA_W-1:0] rd_q;

    always_ff @(posedge wb_clk_i) begin
        for (int b = 0; b < BLOCKS; b++) begin
            if (!bus.ena_n[b]) begin
                if (!bus.wen_n) begin
                    // Byte lanes follow the mask
                    for (int j = 0; j < 4; j++) begin
                        if (bus.wen_mask[j]) begin
                            mem[b][bus.addr][8*j +: 8] <= bus.wdata[8*j +: 8];
                        end
                    end
                end else begin
                    rd_q[b] <= mem[b][bus.addr];
                end
            end
        end
    end

    assign bus.rdata = rd_q;

endmodule

// File: design/user_sram_bank.sv
`timescale 1ns/10ps

module user_sram_bank #(
    parameter int BLOCKS = 4
) (
    input  logic                               wb_clk_i,
    input  logic                               user_we_i,
    input  logic [$clog2(BLOCKS)-1:0]          user_blk_i,
    input  logic [storage_pkg::WORD_ADR_W-1:0] user_addr_i,
    input  logic [storage_pkg::DATA_W-1:0]     user_dat_i,
    mem_bus_if.mem_ro                          bus
);
    import storage_pkg::*;

    logic [DATA_W-1:0]             mem [BLOCKS][2**WORD_ADR_W];
    logic [BLOCKS-1:0][DATA_W-1:0] rd_q;

    // User-area side writes whole words
    always_ff @(posedge wb_clk_i) begin
        for (int b = 0; b < BLOCKS; b++) begin
            if (user_we_i && (int'(user_blk_i) == b)) begin
                mem[b][user_addr_i] <= user_dat_i;
            end
        end
    end

    // Bridge side is read only
    always_ff @(posedge wb_clk_i) begin
        for (int b = 0; b < BLOCKS; b++) begin
            if (!bus.ena_n[b]) begin
                rd_q[b] <= mem[b][bus.addr];
            end
        end
    end

    assign bus.rdata = rd_q;

endmodule

// File: design/storage_subsystem.sv
`timescale 1ns/10ps

module storage_subsystem #(
    parameter int MGMT_BLOCKS = 2,
    parameter int USER_BLOCKS = 4
) (
    input  logic                               wb_clk_i,
    input  logic                               rst_n_i,

    // Wishbone slave
    input  logic [31:0]                        wb_adr_i,
    input  logic [storage_pkg::DATA_W-1:0]     wb_dat_i,
    input  logic [3:0]                         wb_sel_i,
    input  logic                               wb_we_i,
    input  logic                               wb_cyc_i,
    input  logic [1:0]                         wb_stb_i,
    output logic [1:0]                         wb_ack_o,
    output logic [storage_pkg::DATA_W-1:0]     wb_mgmt_dat_o,
    output logic [storage_pkg::DATA_W-1:0]     wb_user_dat_o,

    // User-area fill port
    input  logic                               user_we_i,
    input  logic [$clog2(USER_BLOCKS)-1:0]     user_blk_i,
    input  logic [storage_pkg::WORD_ADR_W-1:0] user_addr_i,
    input  logic [storage_pkg::DATA_W-1:0]     user_dat_i
);
    import storage_pkg::*;

    // Strobe qualified by cyc, bit 0 mgmt and bit 1 user
    logic [1:0] valid;

    mem_bus_if #(
        .BLOCKS (MGMT_BLOCKS)
    ) mgmt_bus ();

    mem_bus_if #(
        .BLOCKS (USER_BLOCKS)
    ) user_bus ();

    storage_ctrl u_ctrl (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_o (wb_ack_o),
        .valid_o  (valid),
        .mgmt_bus (mgmt_bus.writer)
    );

    storage_bank_router #(
        .BLOCKS     (MGMT_BLOCKS),
        .BLOCK_BASE (MGMT_BLOCK_ADR)
    ) u_mgmt_router (
        .valid_i  (valid[0]),
        .wb_adr_i (wb_adr_i),
        .dat_o    (wb_mgmt_dat_o),
        .bus      (mgmt_bus.router)
    );

    storage_bank_router #(
        .BLOCKS     (USER_BLOCKS),
        .BLOCK_BASE (USER_BLOCK_ADR)
    ) u_user_router (
        .valid_i  (valid[1]),
        .wb_adr_i (wb_adr_i),
        .dat_o    (wb_user_dat_o),
        .bus      (user_bus.router)
    );

    mgmt_sram_bank #(
        .BLOCKS (MGMT_BLOCKS)
    ) u_mgmt_bank (
        .wb_clk_i (wb_clk_i),
        .bus      (mgmt_bus.mem_rw)
    );

    // Wishbone writes never reach this bank
    user_sram_bank #(
        .BLOCKS (USER_BLOCKS)
    ) u_user_bank (
        .wb_clk_i    (wb_clk_i),
        .user_we_i   (user_we_i),
        .user_blk_i  (user_blk_i),
        .user_addr_i (user_addr_i),
        .user_dat_i  (user_dat_i),
        .bus         (user_bus.mem_ro)
    );

endmodule

// File: tb/tb_storage_tasks.svh
`ifndef TB_STORAGE_TASKS_SVH
`define TB_STORAGE_TASKS_SVH

// Expected contents of every block
logic [31:0] mgmt_ref [MGMT_BLOCKS][256];
logic [31:0] user_ref [USER_BLOCKS][256];

function automatic logic [31:0] rand_word();
    return $random(seed);
endfunction

// Block index in bits 23:16 and word index in bits 7:0
function automatic logic [31:0] blk_adr(input int blk, input logic [7:0] word);
    return {8'h00, 8'(blk), 8'h00, word};
endfunction

// Only the selected byte lanes take new data
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                            input logic [31:0] new_word,
                                            input logic [3:0]  sel);
    logic [31:0] merged;
    merged = old_word;
    for (int j = 0; j < 4; j++) begin
        if (sel[j]) begin
            merged[8*j +: 8] = new_word[8*j +: 8];
        end
    end
    return merged;
endfunction

task automatic check_word(input string what, input logic [31:0] got,
                          input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else stop_failed($sformatf("MISMATCH at %0t: %s read %h, expected %h",
                               $time, what, got, exp));
endtask

// Starts 1 ns after a rising edge and drives strobe bit port
task automatic wb_access(input int port, input logic we, input logic [31:0] adr,
                         input logic [31:0] dat, input logic [3:0] sel,
                         input int hold, output logic [31:0] rdat);
    int waited;
    int expected_wait;
    expected_wait  = we ? 1 : 2;
    wb_adr_i       = adr;
    wb_dat_i       = dat;
    wb_sel_i       = sel;
    wb_we_i        = we;
    wb_cyc_i       = 1'b1;
    wb_stb_i       = 2'b00;
    wb_stb_i[port] = 1'b1;
    waited         = 0;
    do begin
        @(posedge wb_clk_i);
        #1;
        waited++;
    end while (wb_ack_o[port] !== 1'b1);
    rdat = (port == 0) ? wb_mgmt_dat_o : wb_user_dat_o;
    assert (waited == expected_wait)
    else stop_failed($sformatf("MISMATCH at %0t: ack[%0d] after %0d cycles, expected %0d",
                               $time, port, waited, expected_wait));
    // No second ack while the strobe is held
    repeat (hold) begin
        @(posedge wb_clk_i);
        #1;
        assert (wb_ack_o[port] == 1'b0)
        else stop_failed($sformatf("MISMATCH at %0t: second ack[%0d] with strobe held",
                                   $time, port));
    end
    wb_stb_i = 2'b00;
    wb_cyc_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge wb_clk_i);
    #1;
endtask

task automatic wb_write(input int port, input logic [31:0] adr, input logic [31:0] dat,
                        input logic [3:0] sel, input int hold);
    logic [31:0] ignored;
    wb_access(port, 1'b1, adr, dat, sel, hold, ignored);
endtask

task automatic read_check(input int port, input logic [31:0] adr, input logic [31:0] exp,
                          input int hold, input string what);
    logic [31:0] rdat;
    wb_access(port, 1'b0, adr, 32'h0, 4'hf, hold, rdat);
    check_word(what, rdat, exp);
endtask

task automatic mgmt_write(input int blk, input logic [7:0] word, input logic [31:0] dat,
                          input logic [3:0] sel, input int hold);
    wb_write(0, blk_adr(blk, word), dat, sel, hold);
    mgmt_ref[blk][word] = merge_bytes(mgmt_ref[blk][word], dat, sel);
endtask

task automatic user_fill(input int blk, input logic [7:0] word, input logic [31:0] dat);
    user_we_i   = 1'b1;
    user_blk_i  = USER_BLK_W'(blk);
    user_addr_i = word;
    user_dat_i  = dat;
    @(posedge wb_clk_i);
    #1;
    user_we_i = 1'b0;
    user_ref[blk][word] = dat;
endtask

`endif

// File: tb/tb_storage_subsystem.sv
`timescale 1ns/10ps

module tb_storage_subsystem;

    localparam int MGMT_BLOCKS = 2;
    localparam int USER_BLOCKS = 4;
    localparam int USER_BLK_W  = $clog2(USER_BLOCKS);
    localparam int WORDS       = 32;
    // Traffic takes about 1100 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    // Bits 23:16 that hit neither block group
    localparam logic [7:0] UNMAPPED_TAG [3] = '{8'h04, 8'h7e, 8'hff};

    logic                  wb_clk_i;
    logic                  rst_n_i;
    logic [31:0]           wb_adr_i;
    logic [31:0]           wb_dat_i;
    logic [3:0]            wb_sel_i;
    logic                  wb_we_i;
    logic                  wb_cyc_i;
    logic [1:0]            wb_stb_i;
    logic [1:0]            wb_ack_o;
    logic [31:0]           wb_mgmt_dat_o;
    logic [31:0]           wb_user_dat_o;
    logic                  user_we_i;
    logic [USER_BLK_W-1:0] user_blk_i;
    logic [7:0]            user_addr_i;
    logic [31:0]           user_dat_i;

    integer     seed;
    int         check_count;
    int         cycle_count = 0;
    logic [7:0] word_list [WORDS];

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    `include "tb_storage_tasks.svh"

    storage_subsystem #(
        .MGMT_BLOCKS (MGMT_BLOCKS),
        .USER_BLOCKS (USER_BLOCKS)
    ) storage_subsystem_inst (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_we_i       (wb_we_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_ack_o      (wb_ack_o),
        .wb_mgmt_dat_o (wb_mgmt_dat_o),
        .wb_user_dat_o (wb_user_dat_o),
        .user_we_i     (user_we_i),
        .user_blk_i    (user_blk_i),
        .user_addr_i   (user_addr_i),
        .user_dat_i    (user_dat_i)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    always @(posedge wb_clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_failed($sformatf("Timeout: tests still running after %0d cycles",
                                  TIMEOUT_CYCLES));
        end
    end

    // Acks are single-cycle pulses
    ack_pulse_mgmt: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o[0] |=> !wb_ack_o[0])
        else stop_failed($sformatf("MISMATCH at %0t: ack[0] longer than one cycle", $time));

    ack_pulse_user: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o[1] |=> !wb_ack_o[1])
        else stop_failed($sformatf("MISMATCH at %0t: ack[1] longer than one cycle", $time));

    // An ack needs a qualified strobe before it
    ack_cause_mgmt: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o[0]) |-> $past(wb_cyc_i && wb_stb_i[0]))
        else stop_failed($sformatf("MISMATCH at %0t: ack[0] without strobe", $time));

    ack_cause_user: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(wb_ack_o[1]) |-> $past(wb_cyc_i && wb_stb_i[1]))
        else stop_failed($sformatf("MISMATCH at %0t: ack[1] without strobe", $time));

    task automatic masked_write_readback();
        logic [31:0] dat;
        // Full words first so every byte is known
        for (int b = 0; b < MGMT_BLOCKS; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                dat = rand_word();
                mgmt_write(b, word_list[i], dat, 4'hf, 0);
            end
        end
        for (int b = 0; b < MGMT_BLOCKS; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                dat = rand_word();
                mgmt_write(b, word_list[i], dat, 4'(rand_word()), 0);
            end
        end
        for (int b = 0; b < MGMT_BLOCKS; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                read_check(0, blk_adr(b, word_list[i]), mgmt_ref[b][word_list[i]], 0,
                           $sformatf("mgmt block %0d word %h", b, word_list[i]));
            end
        end
    endtask

    task automatic user_fill_readback();
        for (int b = 0; b < USER_BLOCKS; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                user_fill(b, word_list[i], rand_word());
            end
        end
        for (int b = 0; b < USER_BLOCKS; b++) begin
            for (int i = 0; i < WORDS; i++) begin
                read_check(1, blk_adr(b, word_list[i]), user_ref[b][word_list[i]], 0,
                           $sformatf("user block %0d word %h", b, word_list[i]));
            end
        end
    endtask

    task automatic unmapped_access();
        logic [31:0] adr;
        for (int t = 0; t < 3; t++) begin
            adr = {8'h00, UNMAPPED_TAG[t], 8'h00, word_list[t]};
            wb_write(0, adr, rand_word(), 4'hf, 0);
            wb_write(1, adr, rand_word(), 4'hf, 0);
            read_check(0, adr, 32'h0, 0, "unmapped mgmt read");
            read_check(1, adr, 32'h0, 0, "unmapped user read");
        end
        // Same word indices in every block are untouched
        for (int t = 0; t < 3; t++) begin
            for (int b = 0; b < MGMT_BLOCKS; b++) begin
                read_check(0, blk_adr(b, word_list[t]), mgmt_ref[b][word_list[t]], 0,
                           "mgmt reread after unmapped write");
            end
            for (int b = 0; b < USER_BLOCKS; b++) begin
                read_check(1, blk_adr(b, word_list[t]), user_ref[b][word_list[t]], 0,
                           "user reread after unmapped write");
            end
        end
    endtask

    task automatic ro_write_ignored();
        logic [7:0] w;
        for (int b = 0; b < USER_BLOCKS; b++) begin
            w = word_list[b + 3];
            wb_write(1, blk_adr(b, w), ~user_ref[b][w], 4'hf, 0);
            read_check(1, blk_adr(b, w), user_ref[b][w], 0, "user block after bus write");
        end
    endtask

    task automatic held_strobe_acks();
        logic [7:0]  w;
        logic [31:0] dat;
        w   = word_list[5];
        dat = rand_word();
        mgmt_write(1, w, dat, 4'hf, 4);
        read_check(0, blk_adr(1, w), mgmt_ref[1][w], 3, "mgmt read with held strobe");
        read_check(1, blk_adr(2, w), user_ref[2][w], 3, "user read with held strobe");
        wb_write(1, blk_adr(0, w), rand_word(), 4'hf, 2);
    endtask

    initial begin
        seed        = 32'h4e3b_60ec;
        check_count = 0;
        rst_n_i     = 1'b0;
        wb_adr_i    = 32'h0;
        wb_dat_i    = 32'hffff_ffff;
        // Both strobes request writes while reset is held
        wb_sel_i    = 4'hf;
        wb_we_i     = 1'b1;
        wb_cyc_i    = 1'b1;
        wb_stb_i    = 2'b11;
        user_we_i   = 1'b0;
        user_blk_i  = '0;
        user_addr_i = 8'h0;
        user_dat_i  = 32'h0;
        for (int i = 0; i < WORDS; i++) begin
            word_list[i] = 8'(rand_word());
        end

        repeat (2) begin
            @(posedge wb_clk_i);
            #1;
            assert (wb_ack_o == 2'b00)
            else stop_failed($sformatf("MISMATCH at %0t: ack %b during reset", $time, wb_ack_o));
        end
        wb_stb_i = 2'b00;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
        rst_n_i  = 1'b1;
        @(posedge wb_clk_i);
        #1;
        assert (wb_ack_o == 2'b00)
        else stop_failed($sformatf("MISMATCH at %0t: ack %b after reset", $time, wb_ack_o));

        masked_write_readback();
        user_fill_readback();
        unmapped_access();
        ro_write_ignored();
        held_strobe_acks();

        if (check_count > 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_failed("No read data was checked");
        end
    end

endmodule

// File: sim.f
+incdir+tb
design/storage_pkg.sv
design/mem_bus_if.sv
design/storage_ctrl.sv
design/storage_bank_router.sv
design/mgmt_sram_bank.sv
design/user_sram_bank.sv
design/storage_subsystem.sv
tb/tb_storage_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_storage_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
